//--- verilog/tlb_pkg.sv
package tlb_pkg;

    // tlb geometry
    localparam int TLB_ENTRIES = 16;
    localparam int TLB_INDEX_W = 4;
    localparam int VADDR_W     = 32;
    localparam int VPN2_W      = 19;
    localparam int ASID_W      = 8;
    localparam int PFN_W       = 20;
    localparam int CACHE_W     = 3;

    // maintenance bus
    localparam int WB_DATA_W = 32;
    localparam int WB_ADR_W  = 3;

    // register word addresses
    localparam logic [WB_ADR_W-1:0] REG_ENTRYHI  = 3'd0;
    localparam logic [WB_ADR_W-1:0] REG_ENTRYLO0 = 3'd1;
    localparam logic [WB_ADR_W-1:0] REG_ENTRYLO1 = 3'd2;
    localparam logic [WB_ADR_W-1:0] REG_INDEX    = 3'd3;
    localparam logic [WB_ADR_W-1:0] REG_COMMAND  = 3'd4;

    // values written to REG_COMMAND
    localparam logic [WB_DATA_W-1:0] CMD_TLBWI = 32'd1;
    localparam logic [WB_DATA_W-1:0] CMD_TLBP  = 32'd2;

    // field positions in the cp0-style registers
    localparam int EHI_VPN2_LSB = 13;
    localparam int ELO_PFN_LSB  = 6;
    localparam int ELO_C_LSB    = 3;
    localparam int ELO_D_BIT    = 2;
    localparam int ELO_V_BIT    = 1;
    localparam int ELO_G_BIT    = 0;
    localparam int INDEX_P_BIT  = 31;

    // vaddr bit choosing the odd page of a pair
    localparam int ODD_PAGE_BIT = 12;

    // one physical page of a pair
    typedef struct packed {
        logic [PFN_W-1:0]   pfn;
        logic [CACHE_W-1:0] c;
        logic               d;
        logic               v;
    } tlb_page_t;

    // one stored entry, even/odd page pair
    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        logic              g;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

    typedef tlb_entry_t tlb_entry_array_t [TLB_ENTRIES];

    typedef logic [TLB_ENTRIES-1:0] tlb_match_t;

endpackage

//--- verilog/tlb_maint_regs.sv
`timescale 1ns/1ps

module tlb_maint_regs (
    input  logic                          aclk,
    input  logic                          arst_n,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [tlb_pkg::WB_ADR_W-1:0]  wb_adr,
    input  logic [tlb_pkg::WB_DATA_W-1:0] wb_dat_w,
    output logic                          wb_ack,
    output logic [tlb_pkg::WB_DATA_W-1:0] wb_dat_r,
    input  tlb_pkg::tlb_match_t           probe_match,
    output tlb_pkg::tlb_match_t           write_en,
    output tlb_pkg::tlb_entry_t           write_entry
);
    import tlb_pkg::*;

    // entryhi
    logic [VPN2_W-1:0]      hi_vpn2;
    logic [ASID_W-1:0]      hi_asid;
    // entrylo0 / entrylo1
    tlb_page_t              lo0_page;
    tlb_page_t              lo1_page;
    logic                   lo0_g;
    logic                   lo1_g;
    // index
    logic                   index_p;
    logic [TLB_INDEX_W-1:0] index_val;

    logic                   req;
    logic                   reg_wr;
    logic                   cmd_wr;
    logic                   probe_hit;
    logic [TLB_INDEX_W-1:0] probe_idx;
    logic [WB_DATA_W-1:0]   rd_data;

    function automatic tlb_page_t lo_to_page(input logic [WB_DATA_W-1:0] w);
        tlb_page_t p;
        p.pfn = w[ELO_PFN_LSB +: PFN_W];
        p.c   = w[ELO_C_LSB +: CACHE_W];
        p.d   = w[ELO_D_BIT];
        p.v   = w[ELO_V_BIT];
        return p;
    endfunction

    function automatic logic [WB_DATA_W-1:0] page_to_lo(input tlb_page_t p, input logic g);
        logic [WB_DATA_W-1:0] w;
        w = '0;
        w[ELO_PFN_LSB +: PFN_W] = p.pfn;
        w[ELO_C_LSB +: CACHE_W] = p.c;
        w[ELO_D_BIT]            = p.d;
        w[ELO_V_BIT]            = p.v;
        w[ELO_G_BIT]            = g;
        return w;
    endfunction

    // new request only while no ack is pending
    assign req    = wb_cyc && wb_stb && !wb_ack;
    assign reg_wr = req && wb_we;
    assign cmd_wr = reg_wr && (wb_adr == REG_COMMAND);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
        end else begin
            wb_ack <= req;
            if (req) begin
                wb_dat_r <= rd_data;
            end
        end
    end

    // read mux, command and unused addresses read zero
    always_comb begin
        rd_data = '0;
        case (wb_adr)
            REG_ENTRYHI: begin
                rd_data[EHI_VPN2_LSB +: VPN2_W] = hi_vpn2;
                rd_data[ASID_W-1:0]             = hi_asid;
            end
            REG_ENTRYLO0: rd_data = page_to_lo(lo0_page, lo0_g);
            REG_ENTRYLO1: rd_data = page_to_lo(lo1_page, lo1_g);
            REG_INDEX: begin
                rd_data[INDEX_P_BIT]       = index_p;
                rd_data[TLB_INDEX_W-1:0]   = index_val;
            end
            default: rd_data = '0;
        endcase
    end

    // lowest matching entry wins the probe
    always_comb begin
        probe_hit = |probe_match;
        probe_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (probe_match[i]) begin
                probe_idx = TLB_INDEX_W'(i);
            end
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            hi_vpn2   <= '0;
            hi_asid   <= '0;
            lo0_page  <= '0;
            lo1_page  <= '0;
            lo0_g     <= 1'b0;
            lo1_g     <= 1'b0;
            index_p   <= 1'b0;
            index_val <= '0;
        end else begin
            if (reg_wr) begin
                case (wb_adr)
                    REG_ENTRYHI: begin
                        hi_vpn2 <= wb_dat_w[EHI_VPN2_LSB +: VPN2_W];
                        hi_asid <= wb_dat_w[ASID_W-1:0];
                    end
                    REG_ENTRYLO0: begin
                        lo0_page <= lo_to_page(wb_dat_w);
                        lo0_g    <= wb_dat_w[ELO_G_BIT];
                    end
                    REG_ENTRYLO1: begin
                        lo1_page <= lo_to_page(wb_dat_w);
                        lo1_g    <= wb_dat_w[ELO_G_BIT];
                    end
                    REG_INDEX: begin
                        index_p   <= wb_dat_w[INDEX_P_BIT];
                        index_val <= wb_dat_w[TLB_INDEX_W-1:0];
                    end
                    default: ;
                endcase
            end
            // tlbp, a miss keeps the old index bits
            if (cmd_wr && (wb_dat_w == CMD_TLBP)) begin
                index_p <= !probe_hit;
                if (probe_hit) begin
                    index_val <= probe_idx;
                end
            end
        end
    end

    // tlbwi strobe lands in the entry on the ack edge
    always_comb begin
        write_en = '0;
        if (cmd_wr && (wb_dat_w == CMD_TLBWI)) begin
            write_en[index_val] = 1'b1;
        end
    end

    // also the probe key and the current asid
    always_comb begin
        write_entry.vpn2  = hi_vpn2;
        write_entry.asid  = hi_asid;
        write_entry.g     = lo0_g & lo1_g;
        write_entry.page0 = lo0_page;
        write_entry.page1 = lo1_page;
    end

endmodule

//--- verilog/tlb_entry.sv
`timescale 1ns/1ps

module tlb_entry (
    input  logic                        aclk,
    input  logic                        arst_n,
    input  logic                        write_en,
    input  tlb_pkg::tlb_entry_t         write_entry,
    input  logic [tlb_pkg::VADDR_W-1:0] i_vaddr,
    input  logic [tlb_pkg::VADDR_W-1:0] d_vaddr,
    output logic                        i_match,
    output logic                        d_match,
    output logic                        probe_match,
    output tlb_pkg::tlb_entry_t         entry
);
    import tlb_pkg::*;

    logic asid_ok;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            entry <= '0;
        end else if (write_en) begin
            entry <= write_entry;
        end
    end

    // global entries ignore the current asid
    assign asid_ok = entry.g || (entry.asid == write_entry.asid);

    // three independent comparators over the same entry
    assign i_match     = asid_ok && (entry.vpn2 == i_vaddr[EHI_VPN2_LSB +: VPN2_W]);
    assign d_match     = asid_ok && (entry.vpn2 == d_vaddr[EHI_VPN2_LSB +: VPN2_W]);
    assign probe_match = asid_ok && (entry.vpn2 == write_entry.vpn2);

endmodule

//--- verilog/tlb_lookup_port.sv
`timescale 1ns/1ps

module tlb_lookup_port (
    input  logic                        aclk,
    input  logic                        arst_n,
    input  tlb_pkg::tlb_match_t         match,
    input  tlb_pkg::tlb_entry_array_t   entries,
    input  logic                        odd_page,
    output logic                        found,
    output logic [tlb_pkg::PFN_W-1:0]   pfn,
    output logic [tlb_pkg::CACHE_W-1:0] c,
    output logic                        d,
    output logic                        v
);
    import tlb_pkg::*;

    tlb_entry_t sel_entry;
    tlb_page_t  sel_page;
    logic       hit;
    tlb_page_t  page_q;

    // lowest index wins when several entries match
    always_comb begin
        hit       = |match;
        sel_entry = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                sel_entry = entries[i];
            end
        end
    end

    assign sel_page = odd_page ? sel_entry.page1 : sel_entry.page0;

    // single result stage, zero fields on a miss
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            found  <= 1'b0;
            page_q <= '0;
        end else begin
            found  <= hit;
            page_q <= hit ? sel_page : '0;
        end
    end

    assign pfn = page_q.pfn;
    assign c   = page_q.c;
    assign d   = page_q.d;
    assign v   = page_q.v;

endmodule

//--- verilog/mips_tlb.sv
`timescale 1ns/1ps

module mips_tlb (
    input  logic                          aclk,
    input  logic                          arst_n,
    // maintenance port, wishbone classic slave
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [tlb_pkg::WB_ADR_W-1:0]  wb_adr,
    input  logic [tlb_pkg::WB_DATA_W-1:0] wb_dat_w,
    output logic                          wb_ack,
    output logic [tlb_pkg::WB_DATA_W-1:0] wb_dat_r,
    // lookup addresses
    input  logic [tlb_pkg::VADDR_W-1:0]   i_vaddr,
    input  logic [tlb_pkg::VADDR_W-1:0]   d_vaddr,
    // instruction side result
    output logic                          i_found,
    output logic [tlb_pkg::PFN_W-1:0]     i_pfn,
    output logic [tlb_pkg::CACHE_W-1:0]   i_c,
    output logic                          i_d,
    output logic                          i_v,
    // data side result
    output logic                          d_found,
    output logic [tlb_pkg::PFN_W-1:0]     d_pfn,
    output logic [tlb_pkg::CACHE_W-1:0]   d_c,
    output logic                          d_d,
    output logic                          d_v
);
    import tlb_pkg::*;

    tlb_match_t       write_en;
    tlb_entry_t       write_entry;
    tlb_match_t       probe_match;
    tlb_match_t       i_match;
    tlb_match_t       d_match;
    tlb_entry_array_t entries;

    tlb_maint_regs u_maint (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_ack      (wb_ack),
        .wb_dat_r    (wb_dat_r),
        .probe_match (probe_match),
        .write_en    (write_en),
        .write_entry (write_entry)
    );

    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_entry
        tlb_entry u_entry (
            .aclk        (aclk),
            .arst_n      (arst_n),
            .write_en    (write_en[i]),
            .write_entry (write_entry),
            .i_vaddr     (i_vaddr),
            .d_vaddr     (d_vaddr),
            .i_match     (i_match[i]),
            .d_match     (d_match[i]),
            .probe_match (probe_match[i]),
            .entry       (entries[i])
        );
    end

    // instruction fetch port
    tlb_lookup_port u_itlb (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .match    (i_match),
        .entries  (entries),
        .odd_page (i_vaddr[ODD_PAGE_BIT]),
        .found    (i_found),
        .pfn      (i_pfn),
        .c        (i_c),
        .d        (i_d),
        .v        (i_v)
    );

    // data access port
    tlb_lookup_port u_dtlb (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .match    (d_match),
        .entries  (entries),
        .odd_page (d_vaddr[ODD_PAGE_BIT]),
        .found    (d_found),
        .pfn      (d_pfn),
        .c        (d_c),
        .d        (d_d),
        .v        (d_v)
    );

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic aclk,
    output logic arst_n
);
    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 2;

    initial begin
        aclk = 1'b0;
        forever #(HALF_PERIOD) aclk = ~aclk;
    end

    // release lines up with a rising edge
    initial begin
        arst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        arst_n <= 1'b1;
    end

endmodule

//--- tests/tb_mips_tlb.sv
`timescale 1ns/1ps

module tb_mips_tlb;
    import tlb_pkg::*;

    localparam logic [1:0] K_WR   = 2'd0;
    localparam logic [1:0] K_RD   = 2'd1;
    localparam logic [1:0] K_LK   = 2'd2;
    localparam int         N_RAND = 200;

    // lookup rows carry the i address in data and the d address in exp
    typedef struct packed {
        logic [1:0]  kind;
        logic [2:0]  adr;
        logic [31:0] data;
        logic [31:0] exp;
    } row_t;

    logic                 aclk, arst_n;
    logic                 wb_cyc, wb_stb, wb_we, wb_ack;
    logic [WB_ADR_W-1:0]  wb_adr;
    logic [WB_DATA_W-1:0] wb_dat_w, wb_dat_r;
    logic [31:0]          i_vaddr, d_vaddr;
    logic                 i_found, i_d, i_v, d_found, d_d, d_v;
    logic [PFN_W-1:0]     i_pfn, d_pfn;
    logic [CACHE_W-1:0]   i_c, d_c;

    // reference copy of the cp0 registers and the sixteen entries
    logic [31:0] m_hi, m_lo0, m_lo1, m_index;
    tlb_entry_t  m_ent [16];

    row_t        rows [$];
    logic [63:0] pending [$];
    bit          rows_built;
    int          checks;
    int          errors;

    tb_clock_gen u_clk (.aclk(aclk), .arst_n(arst_n));

    mips_tlb dut (.*);

    function automatic logic [31:0] ehi(input logic [18:0] vpn2, input logic [7:0] asid);
        return {vpn2, 5'b0, asid};
    endfunction

    // dvg packs d, v and g in that order
    function automatic logic [31:0] elo(input logic [19:0] pfn, input logic [2:0] c,
                                        input logic [2:0] dvg);
        return {6'b0, pfn, c, dvg};
    endfunction

    function automatic logic entry_hits(input int i, input logic [18:0] vpn2);
        return m_ent[i].vpn2 == vpn2 && (m_ent[i].g || m_ent[i].asid == m_hi[7:0]);
    endfunction

    function automatic logic [25:0] model_lookup(input logic [31:0] vaddr);
        logic [25:0] res;
        res = '0;
        // scan downward so the lowest match is kept
        for (int i = 15; i >= 0; i--) begin
            if (entry_hits(i, vaddr[31:13])) begin
                res = {1'b1, vaddr[12] ? m_ent[i].page1 : m_ent[i].page0};
            end
        end
        return res;
    endfunction

    function automatic void model_write(input logic [2:0] adr, input logic [31:0] data);
        int hit;
        hit = -1;
        case (adr)
            REG_ENTRYHI:  m_hi = data & 32'hFFFF_E0FF;
            REG_ENTRYLO0: m_lo0 = data & 32'h03FF_FFFF;
            REG_ENTRYLO1: m_lo1 = data & 32'h03FF_FFFF;
            REG_INDEX:    m_index = data & 32'h8000_000F;
            REG_COMMAND: begin
                if (data == 32'd1) begin
                    m_ent[m_index[3:0]] = {m_hi[31:13], m_hi[7:0], m_lo0[0] & m_lo1[0],
                                           m_lo0[25:1], m_lo1[25:1]};
                end else if (data == 32'd2) begin
                    for (int i = 15; i >= 0; i--) begin
                        if (entry_hits(i, m_hi[31:13])) begin
                            hit = i;
                        end
                    end
                    m_index = (hit < 0) ? (m_index | 32'h8000_0000) : 32'(hit);
                end
            end
            default: ;
        endcase
    endfunction

    function automatic logic [31:0] rand_addr();
        logic [31:0] raw;
        int unsigned r;
        raw = $urandom;
        r   = $urandom % 16;
        // half of the addresses reuse a stored vpn2
        if (raw[31]) begin
            return {m_ent[r].vpn2, raw[12:0]};
        end
        return raw;
    endfunction

    function automatic void check_port(input string port, input logic [31:0] vaddr,
                                       input logic [25:0] want, input logic [25:0] got);
        checks++;
        assert (got == want) else begin
            errors++;
            $display("FAIL %0t: %s-port lookup of %h returned %h, expected %h",
                     $time, port, vaddr, got, want);
        end
    endfunction

    task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] data,
                             output logic [31:0] rdata);
        int waited;
        @(posedge aclk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= data;
        waited = 0;
        do begin
            @(negedge aclk);
            waited++;
        end while (!wb_ack && waited < 4);
        assert (wb_ack) else begin
            errors++;
            $display("error at %0t: no wb_ack within 4 cycles for register %0d", $time, adr);
        end
        rdata = wb_dat_r;
        @(posedge aclk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic lookup_pair(input logic [31:0] ia, input logic [31:0] da);
        logic [25:0] i_want, d_want;
        i_want = model_lookup(ia);
        d_want = model_lookup(da);
        @(posedge aclk);
        i_vaddr <= ia;
        d_vaddr <= da;
        // sampled on the next edge and stable by the falling edge after it
        @(posedge aclk);
        @(negedge aclk);
        check_port("i", ia, i_want, {i_found, i_pfn, i_c, i_d, i_v});
        check_port("d", da, d_want, {d_found, d_pfn, d_c, d_d, d_v});
    endtask

    function automatic void program_entry(input logic [3:0] idx, input logic [31:0] hi,
                                          input logic [31:0] lo0, input logic [31:0] lo1);
        rows.push_back({K_WR, REG_ENTRYHI, hi, 32'h0});
        rows.push_back({K_WR, REG_ENTRYLO0, lo0, 32'h0});
        rows.push_back({K_WR, REG_ENTRYLO1, lo1, 32'h0});
        rows.push_back({K_WR, REG_INDEX, {28'h0, idx}, 32'h0});
        rows.push_back({K_WR, REG_COMMAND, 32'd1, 32'h0});
    endfunction

    function automatic void build_table();
        // zeroed entries after reset let vpn2 0 at asid 0 hit entry 0
        rows.push_back({K_LK, 3'd0, 32'h0000_0000, 32'h0000_1000});
        rows.push_back({K_LK, 3'd0, 32'h8000_0000, 32'h1234_5000});
        rows.push_back({K_RD, REG_INDEX, 32'h0, 32'h0});
        // read-back through the field masks
        rows.push_back({K_WR, REG_ENTRYHI, 32'hFFFF_FFFF, 32'h0});
        rows.push_back({K_RD, REG_ENTRYHI, 32'h0, 32'hFFFF_E0FF});
        rows.push_back({K_WR, REG_ENTRYLO0, 32'hFFFF_FFFF, 32'h0});
        rows.push_back({K_RD, REG_ENTRYLO0, 32'h0, 32'h03FF_FFFF});
        rows.push_back({K_WR, REG_ENTRYLO1, 32'hA5A5_A5A5, 32'h0});
        rows.push_back({K_RD, REG_ENTRYLO1, 32'h0, 32'h01A5_A5A5});
        rows.push_back({K_WR, REG_INDEX, 32'hFFFF_FFFF, 32'h0});
        rows.push_back({K_RD, REG_INDEX, 32'h0, 32'h8000_000F});
        rows.push_back({K_RD, REG_COMMAND, 32'h0, 32'h0});
        // tlbwi with entry 9 as a global mapping
        program_entry(4'd2, ehi(19'h00400, 8'h11),
                      elo(20'h12345, 3'd3, 3'b110), elo(20'h12346, 3'd2, 3'b010));
        program_entry(4'd5, ehi(19'h40000, 8'h11),
                      elo(20'hABCDE, 3'd5, 3'b010), elo(20'hABCDF, 3'd7, 3'b100));
        program_entry(4'd9, ehi(19'h7FFFF, 8'h11),
                      elo(20'h00F00, 3'd0, 3'b111), elo(20'h00F01, 3'd1, 3'b111));
        rows.push_back({K_LK, 3'd0, 32'h0080_0123, 32'h0080_1456});
        rows.push_back({K_LK, 3'd0, 32'h0080_1FFC, 32'h0080_0000});
        rows.push_back({K_LK, 3'd0, 32'h8000_1ABC, 32'h8000_0FFC});
        rows.push_back({K_LK, 3'd0, 32'h8000_0010, 32'h8000_1010});
        rows.push_back({K_LK, 3'd0, 32'hFFFF_E000, 32'hFFFF_F004});
        rows.push_back({K_LK, 3'd0, 32'hFFFF_F800, 32'hFFFF_E800});
        // overwriting index 5 drops the old pair
        program_entry(4'd5, ehi(19'h12345, 8'h11),
                      elo(20'h55555, 3'd1, 3'b010), elo(20'h55556, 3'd6, 3'b110));
        rows.push_back({K_LK, 3'd0, 32'h8000_0000, 32'h2468_A000});
        rows.push_back({K_LK, 3'd0, 32'h2468_B000, 32'h8000_1000});
        // under another asid only the global entry hits
        rows.push_back({K_WR, REG_ENTRYHI, ehi(19'h0, 8'h22), 32'h0});
        rows.push_back({K_LK, 3'd0, 32'h0080_0000, 32'hFFFF_F000});
        rows.push_back({K_WR, REG_ENTRYHI, ehi(19'h0, 8'h11), 32'h0});
        rows.push_back({K_LK, 3'd0, 32'h0080_1000, 32'h2468_A000});
        // tlbp hit over a stale index, miss, then a duplicate of entry 2 at index 12
        rows.push_back({K_WR, REG_ENTRYHI, ehi(19'h12345, 8'h11), 32'h0});
        rows.push_back({K_WR, REG_INDEX, 32'h8000_000A, 32'h0});
        rows.push_back({K_WR, REG_COMMAND, 32'd2, 32'h0});
        rows.push_back({K_RD, REG_INDEX, 32'h0, 32'h0000_0005});
        rows.push_back({K_WR, REG_ENTRYHI, ehi(19'h3AAAA, 8'h11), 32'h0});
        rows.push_back({K_WR, REG_COMMAND, 32'd2, 32'h0});
        rows.push_back({K_RD, REG_INDEX, 32'h0, 32'h8000_0005});
        program_entry(4'd12, ehi(19'h00400, 8'h11),
                      elo(20'h77777, 3'd4, 3'b010), elo(20'h77778, 3'd4, 3'b010));
        rows.push_back({K_WR, REG_COMMAND, 32'd2, 32'h0});
        rows.push_back({K_RD, REG_INDEX, 32'h0, 32'h0000_0002});
        rows.push_back({K_LK, 3'd0, 32'h0080_0000, 32'h0080_1000});
    endfunction

    initial begin
        logic [31:0] rdata, ia, da, pa, pd;
        void'($urandom(53));
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        wb_adr   <= '0;
        wb_dat_w <= '0;
        i_vaddr  <= '0;
        d_vaddr  <= '0;
        m_hi    = '0;
        m_lo0   = '0;
        m_lo1   = '0;
        m_index = '0;
        foreach (m_ent[i]) begin
            m_ent[i] = '0;
        end
        build_table();
        rows_built = 1'b1;
        wait (arst_n);
        foreach (rows[n]) begin
            case (rows[n].kind)
                K_WR: begin
                    wb_access(1'b1, rows[n].adr, rows[n].data, rdata);
                    model_write(rows[n].adr, rows[n].data);
                end
                K_RD: begin
                    wb_access(1'b0, rows[n].adr, 32'h0, rdata);
                    checks++;
                    assert (rdata == rows[n].exp) else begin
                        errors++;
                        $display("FAIL %0t: register %0d read %h, expected %h",
                                 $time, rows[n].adr, rdata, rows[n].exp);
                    end
                end
                default: lookup_pair(rows[n].data, rows[n].exp);
            endcase
        end
        // new addresses every cycle on both ports with one result in flight each
        for (int n = 0; n <= N_RAND; n++) begin
            @(posedge aclk);
            if (n < N_RAND) begin
                ia = rand_addr();
                da = rand_addr();
                i_vaddr <= ia;
                d_vaddr <= da;
                pending.push_back({ia, da});
            end
            @(negedge aclk);
            if (n > 0) begin
                {pa, pd} = pending.pop_front();
                check_port("i", pa, model_lookup(pa), {i_found, i_pfn, i_c, i_d, i_v});
                check_port("d", pd, model_lookup(pd), {d_found, d_pfn, d_c, d_d, d_v});
            end
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        int limit;
        wait (rows_built);
        // a few cycles per row plus one per random pair
        limit = rows.size() * 8 + N_RAND + 50;
        repeat (limit) @(posedge aclk);
        $display("timeout: run still busy after %0d clock cycles", limit);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- mips_tlb.f
verilog/tlb_pkg.sv
verilog/tlb_maint_regs.sv
verilog/tlb_entry.sv
verilog/tlb_lookup_port.sv
verilog/mips_tlb.sv
tests/tb_clock_gen.sv
tests/tb_mips_tlb.sv

//--- Makefile
BIN  = obj_dir/Vtb_mips_tlb
SRCS = $(wildcard verilog/*.sv tests/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): mips_tlb.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_mips_tlb -f mips_tlb.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
